//--- src/csr_pkg.sv
`default_nettype none

package csr_pkg;

	localparam int xlen = 32;
	localparam int csr_num_w = 14;

	// register numbers
	localparam logic [csr_num_w-1:0] csr_crmd = 14'h0;
	localparam logic [csr_num_w-1:0] csr_prmd = 14'h1;
	localparam logic [csr_num_w-1:0] csr_ecfg = 14'h4;
	localparam logic [csr_num_w-1:0] csr_estat = 14'h5;
	localparam logic [csr_num_w-1:0] csr_era = 14'h6;
	localparam logic [csr_num_w-1:0] csr_badv = 14'h7;
	localparam logic [csr_num_w-1:0] csr_eentry = 14'hc;
	// save register k sits at csr_save0 + k
	localparam logic [csr_num_w-1:0] csr_save0 = 14'h30;
	localparam logic [csr_num_w-1:0] csr_tid = 14'h40;
	localparam logic [csr_num_w-1:0] csr_tcfg = 14'h41;
	localparam logic [csr_num_w-1:0] csr_tavl = 14'h42;
	localparam logic [csr_num_w-1:0] csr_ticlr = 14'h44;

	// cause fields
	localparam int ecode_w = 6;
	localparam int esubcode_w = 9;

	// address errors, the only codes that update badv
	localparam logic [ecode_w-1:0] ecode_ade = 6'h8;
	localparam logic [ecode_w-1:0] ecode_ale = 6'h9;

	// interrupt status
	localparam int int_w = 13;
	localparam int timer_int_bit = 11;

	// new bits where mask is set, old bits elsewhere
	function automatic logic [xlen-1:0] csr_masked_write(
		input logic [xlen-1:0] old_value,
		input logic [xlen-1:0] new_value,
		input logic [xlen-1:0] mask
	);
		return (mask & new_value) | (~mask & old_value);
	endfunction

endpackage

`default_nettype wire

//--- src/csr_exc_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_exc_regs
	import csr_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,

	input  logic                  csr_we,
	input  logic [csr_num_w-1:0]  csr_wnum,
	input  logic [xlen-1:0]       csr_wmask,
	input  logic [xlen-1:0]       csr_wvalue,

	input  logic                  wb_ex,
	input  logic [ecode_w-1:0]    wb_ecode,
	input  logic [esubcode_w-1:0] wb_esubcode,
	input  logic [xlen-1:0]       wb_pc,
	input  logic [xlen-1:0]       wb_vaddr,
	input  logic                  ws_mem_inst,
	input  logic                  eret_flush,

	output logic [xlen-1:0]       crmd_value,
	output logic [xlen-1:0]       prmd_value,
	output logic [xlen-1:0]       estat_cause_value,
	output logic [xlen-1:0]       era_value,
	output logic [xlen-1:0]       badv_value,
	output logic [xlen-1:0]       eentry_value,
	output logic                  crmd_ie,
	output logic [xlen-1:0]       ex_entry,
	output logic [xlen-1:0]       ertn_entry
);

	logic [1:0]            crmd_plv;
	logic                  crmd_da;
	logic                  crmd_pg;
	logic [1:0]            prmd_pplv;
	logic                  prmd_pie;
	logic [ecode_w-1:0]    estat_ecode;
	logic [esubcode_w-1:0] estat_esubcode;
	logic [xlen-1:0]       era_pc;
	logic [xlen-1:0]       badv_vaddr;
	logic [xlen-1:6]       eentry_va;

	logic                  wr_crmd;
	logic                  wr_prmd;
	logic                  wr_era;
	logic                  wr_eentry;
	logic [xlen-1:0]       crmd_wdata;
	logic [xlen-1:0]       prmd_wdata;
	logic [xlen-1:0]       era_wdata;
	logic [xlen-1:0]       eentry_wdata;
	logic                  wb_ex_addr_err;

	assign wr_crmd   = csr_we && csr_wnum == csr_crmd;
	assign wr_prmd   = csr_we && csr_wnum == csr_prmd;
	assign wr_era    = csr_we && csr_wnum == csr_era;
	assign wr_eentry = csr_we && csr_wnum == csr_eentry;

	assign crmd_wdata   = csr_masked_write(crmd_value, csr_wvalue, csr_wmask);
	assign prmd_wdata   = csr_masked_write(prmd_value, csr_wvalue, csr_wmask);
	assign era_wdata    = csr_masked_write(era_value, csr_wvalue, csr_wmask);
	assign eentry_wdata = csr_masked_write(eentry_value, csr_wvalue, csr_wmask);

	// exception entry beats eret, both beat software writes
	always_ff @(posedge clk) begin
		if (rst) begin
			crmd_plv <= 2'b0;
			crmd_ie  <= 1'b0;
			crmd_da  <= 1'b1;
			crmd_pg  <= 1'b0;
		end else if (wb_ex) begin
			crmd_plv <= 2'b0;
			crmd_ie  <= 1'b0;
		end else if (eret_flush) begin
			crmd_plv <= prmd_pplv;
			crmd_ie  <= prmd_pie;
		end else if (wr_crmd) begin
			crmd_plv <= crmd_wdata[1:0];
			crmd_ie  <= crmd_wdata[2];
			crmd_da  <= crmd_wdata[3];
			crmd_pg  <= crmd_wdata[4];
		end
	end

	// saved privilege state
	always_ff @(posedge clk) begin
		if (wb_ex) begin
			prmd_pplv <= crmd_plv;
			prmd_pie  <= crmd_ie;
		end else if (wr_prmd) begin
			prmd_pplv <= prmd_wdata[1:0];
			prmd_pie  <= prmd_wdata[2];
		end
	end

	always_ff @(posedge clk) begin
		if (wb_ex) begin
			estat_ecode    <= wb_ecode;
			estat_esubcode <= wb_esubcode;
		end
	end

	always_ff @(posedge clk) begin
		if (wb_ex)
			era_pc <= wb_pc;
		else if (wr_era)
			era_pc <= era_wdata;
	end

	assign wb_ex_addr_err = wb_ecode == ecode_ade || wb_ecode == ecode_ale;

	// fetch errors report the pc, memory errors the data address
	always_ff @(posedge clk) begin
		if (wb_ex && wb_ex_addr_err)
			badv_vaddr <= ws_mem_inst ? wb_vaddr : wb_pc;
	end

	always_ff @(posedge clk) begin
		if (wr_eentry)
			eentry_va <= eentry_wdata[xlen-1:6];
	end

	assign crmd_value        = {{(xlen-5){1'b0}}, crmd_pg, crmd_da, crmd_ie, crmd_plv};
	assign prmd_value        = {{(xlen-3){1'b0}}, prmd_pie, prmd_pplv};
	assign estat_cause_value = {1'b0, estat_esubcode, estat_ecode, 16'b0};
	assign era_value         = era_pc;
	assign badv_value        = badv_vaddr;
	assign eentry_value      = {eentry_va, 6'b0};

	assign ex_entry   = eentry_value;
	assign ertn_entry = era_value;

endmodule

`default_nettype wire

//--- src/csr_int_timer.sv
`timescale 1ns/1ps
`default_nettype none

module csr_int_timer
	import csr_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,

	input  logic                 csr_we,
	input  logic [csr_num_w-1:0] csr_wnum,
	input  logic [xlen-1:0]      csr_wmask,
	input  logic [xlen-1:0]      csr_wvalue,

	input  logic                 crmd_ie,

	output logic [xlen-1:0]      ecfg_value,
	output logic [xlen-1:0]      estat_is_value,
	output logic [xlen-1:0]      tid_value,
	output logic [xlen-1:0]      tcfg_value,
	output logic [xlen-1:0]      tavl_value,
	output logic                 has_int
);

	logic [int_w-1:0] ecfg_lie;
	logic [int_w-1:0] estat_is;
	logic [1:0]       estat_swi;
	logic             estat_ti;
	logic [xlen-1:0]  tid;
	logic             tcfg_en;
	logic             tcfg_periodic;
	logic [xlen-1:2]  tcfg_initval;
	logic [xlen-1:0]  timer_cnt;

	logic             wr_ecfg;
	logic             wr_estat;
	logic             wr_tid;
	logic             wr_tcfg;
	logic             wr_ticlr;
	logic [xlen-1:0]  ecfg_wdata;
	logic [xlen-1:0]  estat_wdata;
	logic [xlen-1:0]  tid_wdata;
	logic [xlen-1:0]  tcfg_wdata;
	logic             cnt_zero;
	logic             cnt_stopped;

	assign wr_ecfg  = csr_we && csr_wnum == csr_ecfg;
	assign wr_estat = csr_we && csr_wnum == csr_estat;
	assign wr_tid   = csr_we && csr_wnum == csr_tid;
	assign wr_tcfg  = csr_we && csr_wnum == csr_tcfg;
	assign wr_ticlr = csr_we && csr_wnum == csr_ticlr;

	assign ecfg_wdata  = csr_masked_write(ecfg_value, csr_wvalue, csr_wmask);
	assign estat_wdata = csr_masked_write(estat_is_value, csr_wvalue, csr_wmask);
	assign tid_wdata   = csr_masked_write(tid_value, csr_wvalue, csr_wmask);
	assign tcfg_wdata  = csr_masked_write(tcfg_value, csr_wvalue, csr_wmask);

	always_ff @(posedge clk) begin
		if (rst)
			ecfg_lie <= '0;
		else if (wr_ecfg)
			ecfg_lie <= ecfg_wdata[int_w-1:0];
	end

	// software interrupt bits
	always_ff @(posedge clk) begin
		if (rst)
			estat_swi <= 2'b0;
		else if (wr_estat)
			estat_swi <= estat_wdata[1:0];
	end

	// timer interrupt, a zero count wins over ticlr
	always_ff @(posedge clk) begin
		if (rst)
			estat_ti <= 1'b0;
		else if (cnt_zero)
			estat_ti <= 1'b1;
		else if (wr_ticlr && csr_wmask[0] && csr_wvalue[0])
			estat_ti <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rst)
			tid <= '0;
		else if (wr_tid)
			tid <= tid_wdata;
	end

	always_ff @(posedge clk) begin
		if (rst)
			tcfg_en <= 1'b0;
		else if (wr_tcfg)
			tcfg_en <= tcfg_wdata[0];
	end

	always_ff @(posedge clk) begin
		if (wr_tcfg) begin
			tcfg_periodic <= tcfg_wdata[1];
			tcfg_initval  <= tcfg_wdata[xlen-1:2];
		end
	end

	assign cnt_zero    = timer_cnt == '0;
	assign cnt_stopped = &timer_cnt;

	// one-shot wraps to all ones and parks there
	always_ff @(posedge clk) begin
		if (rst)
			timer_cnt <= '1;
		else if (wr_tcfg && tcfg_wdata[0])
			timer_cnt <= {tcfg_wdata[xlen-1:2], 2'b0};
		else if (tcfg_en && !cnt_stopped) begin
			if (cnt_zero && tcfg_periodic)
				timer_cnt <= {tcfg_initval, 2'b0};
			else
				timer_cnt <= timer_cnt - 1'b1;
		end
	end

	always_comb begin
		estat_is = '0;
		estat_is[1:0] = estat_swi;
		estat_is[timer_int_bit] = estat_ti;
	end

	assign ecfg_value     = {{(xlen-int_w){1'b0}}, ecfg_lie};
	assign estat_is_value = {{(xlen-int_w){1'b0}}, estat_is};
	assign tid_value      = tid;
	assign tcfg_value     = {tcfg_initval, tcfg_periodic, tcfg_en};
	assign tavl_value     = timer_cnt;

	assign has_int = (|(estat_is[timer_int_bit:0] & ecfg_lie[timer_int_bit:0])) && crmd_ie;

endmodule

`default_nettype wire

//--- src/csr_save_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_save_regs
	import csr_pkg::*;
#(
	parameter int num_save = 4
) (
	input  logic                           clk,

	input  logic                           csr_we,
	input  logic [csr_num_w-1:0]           csr_wnum,
	input  logic [xlen-1:0]                csr_wmask,
	input  logic [xlen-1:0]                csr_wvalue,

	output logic [num_save-1:0][xlen-1:0]  save_values
);

	// scratch words at consecutive numbers from save0
	always_ff @(posedge clk) begin
		for (int k = 0; k < num_save; k++) begin
			if (csr_we && csr_wnum == csr_num_w'(csr_save0 + k))
				save_values[k] <= csr_masked_write(save_values[k], csr_wvalue, csr_wmask);
		end
	end

endmodule

`default_nettype wire

//--- src/csr_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux
	import csr_pkg::*;
#(
	parameter int num_save = 4
) (
	input  logic                          csr_re,
	input  logic [csr_num_w-1:0]          csr_rnum,

	input  logic [xlen-1:0]               crmd_value,
	input  logic [xlen-1:0]               prmd_value,
	input  logic [xlen-1:0]               estat_cause_value,
	input  logic [xlen-1:0]               era_value,
	input  logic [xlen-1:0]               badv_value,
	input  logic [xlen-1:0]               eentry_value,
	input  logic [xlen-1:0]               ecfg_value,
	input  logic [xlen-1:0]               estat_is_value,
	input  logic [xlen-1:0]               tid_value,
	input  logic [xlen-1:0]               tcfg_value,
	input  logic [xlen-1:0]               tavl_value,
	input  logic [num_save-1:0][xlen-1:0] save_values,

	output logic [xlen-1:0]               csr_rvalue
);

	logic [xlen-1:0] estat_value;

	// cause and status fields never overlap
	assign estat_value = estat_cause_value | estat_is_value;

	// ticlr and unknown numbers fall through as zero
	always_comb begin
		csr_rvalue = '0;
		if (csr_re) begin
			csr_rvalue = {xlen{csr_rnum == csr_crmd}} & crmd_value
				| {xlen{csr_rnum == csr_prmd}} & prmd_value
				| {xlen{csr_rnum == csr_ecfg}} & ecfg_value
				| {xlen{csr_rnum == csr_estat}} & estat_value
				| {xlen{csr_rnum == csr_era}} & era_value
				| {xlen{csr_rnum == csr_badv}} & badv_value
				| {xlen{csr_rnum == csr_eentry}} & eentry_value
				| {xlen{csr_rnum == csr_tid}} & tid_value
				| {xlen{csr_rnum == csr_tcfg}} & tcfg_value
				| {xlen{csr_rnum == csr_tavl}} & tavl_value;
			for (int k = 0; k < num_save; k++) begin
				csr_rvalue = csr_rvalue
					| {xlen{csr_rnum == csr_num_w'(csr_save0 + k)}} & save_values[k];
			end
		end
	end

endmodule

`default_nettype wire

//--- src/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file
	import csr_pkg::*;
#(
	parameter int num_save = 4
) (
	input  logic                  clk,
	input  logic                  rst,

	input  logic                  csr_re,
	input  logic [csr_num_w-1:0]  csr_rnum,
	output logic [xlen-1:0]       csr_rvalue,

	input  logic                  csr_we,
	input  logic [csr_num_w-1:0]  csr_wnum,
	input  logic [xlen-1:0]       csr_wmask,
	input  logic [xlen-1:0]       csr_wvalue,

	input  logic                  wb_ex,
	input  logic [ecode_w-1:0]    wb_ecode,
	input  logic [esubcode_w-1:0] wb_esubcode,
	input  logic [xlen-1:0]       wb_pc,
	input  logic [xlen-1:0]       wb_vaddr,
	input  logic                  ws_mem_inst,
	input  logic                  eret_flush,

	output logic                  has_int,
	output logic [xlen-1:0]       ex_entry,
	output logic [xlen-1:0]       ertn_entry,
	output logic [xlen-1:0]       tid_rvalue
);

	logic [xlen-1:0]               crmd_value;
	logic [xlen-1:0]               prmd_value;
	logic [xlen-1:0]               estat_cause_value;
	logic [xlen-1:0]               era_value;
	logic [xlen-1:0]               badv_value;
	logic [xlen-1:0]               eentry_value;
	logic [xlen-1:0]               ecfg_value;
	logic [xlen-1:0]               estat_is_value;
	logic [xlen-1:0]               tid_value;
	logic [xlen-1:0]               tcfg_value;
	logic [xlen-1:0]               tavl_value;
	logic [num_save-1:0][xlen-1:0] save_values;
	logic                          crmd_ie;

	csr_exc_regs u_exc_regs (
		.clk               (clk),
		.rst               (rst),
		.csr_we            (csr_we),
		.csr_wnum          (csr_wnum),
		.csr_wmask         (csr_wmask),
		.csr_wvalue        (csr_wvalue),
		.wb_ex             (wb_ex),
		.wb_ecode          (wb_ecode),
		.wb_esubcode       (wb_esubcode),
		.wb_pc             (wb_pc),
		.wb_vaddr          (wb_vaddr),
		.ws_mem_inst       (ws_mem_inst),
		.eret_flush        (eret_flush),
		.crmd_value        (crmd_value),
		.prmd_value        (prmd_value),
		.estat_cause_value (estat_cause_value),
		.era_value         (era_value),
		.badv_value        (badv_value),
		.eentry_value      (eentry_value),
		.crmd_ie           (crmd_ie),
		.ex_entry          (ex_entry),
		.ertn_entry        (ertn_entry)
	);

	csr_int_timer u_int_timer (
		.clk            (clk),
		.rst            (rst),
		.csr_we         (csr_we),
		.csr_wnum       (csr_wnum),
		.csr_wmask      (csr_wmask),
		.csr_wvalue     (csr_wvalue),
		.crmd_ie        (crmd_ie),
		.ecfg_value     (ecfg_value),
		.estat_is_value (estat_is_value),
		.tid_value      (tid_value),
		.tcfg_value     (tcfg_value),
		.tavl_value     (tavl_value),
		.has_int        (has_int)
	);

	csr_save_regs #(
		.num_save (num_save)
	) u_save_regs (
		.clk         (clk),
		.csr_we      (csr_we),
		.csr_wnum    (csr_wnum),
		.csr_wmask   (csr_wmask),
		.csr_wvalue  (csr_wvalue),
		.save_values (save_values)
	);

	csr_read_mux #(
		.num_save (num_save)
	) u_read_mux (
		.csr_re            (csr_re),
		.csr_rnum          (csr_rnum),
		.crmd_value        (crmd_value),
		.prmd_value        (prmd_value),
		.estat_cause_value (estat_cause_value),
		.era_value         (era_value),
		.badv_value        (badv_value),
		.eentry_value      (eentry_value),
		.ecfg_value        (ecfg_value),
		.estat_is_value    (estat_is_value),
		.tid_value         (tid_value),
		.tcfg_value        (tcfg_value),
		.tavl_value        (tavl_value),
		.save_values       (save_values),
		.csr_rvalue        (csr_rvalue)
	);

	// core id for the rdcnt path
	assign tid_rvalue = tid_value;

endmodule

`default_nettype wire

//--- tests/csr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_tb
	import csr_pkg::*;
();

	localparam int num_save = 4;
	// rough cycle count of all tests together
	localparam int test_cycles = 400;

	logic                  clk = 1'b0;
	logic                  rst;
	logic                  csr_re;
	logic [csr_num_w-1:0]  csr_rnum;
	logic [xlen-1:0]       csr_rvalue;
	logic                  csr_we;
	logic [csr_num_w-1:0]  csr_wnum;
	logic [xlen-1:0]       csr_wmask;
	logic [xlen-1:0]       csr_wvalue;
	logic                  wb_ex;
	logic [ecode_w-1:0]    wb_ecode;
	logic [esubcode_w-1:0] wb_esubcode;
	logic [xlen-1:0]       wb_pc;
	logic [xlen-1:0]       wb_vaddr;
	logic                  ws_mem_inst;
	logic                  eret_flush;
	logic                  has_int;
	logic [xlen-1:0]       ex_entry;
	logic [xlen-1:0]       ertn_entry;
	logic [xlen-1:0]       tid_rvalue;

	// expected register words by register number
	logic [xlen-1:0]       ref_regs [0:127];
	logic [xlen-1:0]       ref_cause;
	logic                  ref_ti;

	csr_file #(
		.num_save (num_save)
	) dut (
		.clk         (clk),
		.rst         (rst),
		.csr_re      (csr_re),
		.csr_rnum    (csr_rnum),
		.csr_rvalue  (csr_rvalue),
		.csr_we      (csr_we),
		.csr_wnum    (csr_wnum),
		.csr_wmask   (csr_wmask),
		.csr_wvalue  (csr_wvalue),
		.wb_ex       (wb_ex),
		.wb_ecode    (wb_ecode),
		.wb_esubcode (wb_esubcode),
		.wb_pc       (wb_pc),
		.wb_vaddr    (wb_vaddr),
		.ws_mem_inst (ws_mem_inst),
		.eret_flush  (eret_flush),
		.has_int     (has_int),
		.ex_entry    (ex_entry),
		.ertn_entry  (ertn_entry),
		.tid_rvalue  (tid_rvalue)
	);

	always #20 clk = ~clk;

	function automatic logic [xlen-1:0] merge_bits(
		input logic [xlen-1:0] old_bits,
		input logic [xlen-1:0] new_bits,
		input logic [xlen-1:0] mask
	);
		return (new_bits & mask) | (old_bits & ~mask);
	endfunction

	// mask of implemented bits per register
	function automatic logic [xlen-1:0] keep_bits(input logic [csr_num_w-1:0] num);
		case (num)
			csr_crmd:   return 32'h1f;
			csr_prmd:   return 32'h7;
			csr_ecfg:   return 32'h1fff;
			csr_estat:  return 32'h3;
			csr_eentry: return 32'hffffffc0;
			csr_ticlr:  return 32'h0;
			default:    return 32'hffffffff;
		endcase
	endfunction

	function automatic logic [csr_num_w-1:0] rw_reg(input int idx);
		case (idx)
			0, 1, 2, 3: return csr_save0 + csr_num_w'(idx);
			4:          return csr_eentry;
			5:          return csr_era;
			6:          return csr_ecfg;
			7:          return csr_prmd;
			default:    return csr_tid;
		endcase
	endfunction

	function automatic logic [ecode_w-1:0] ex_code(input int idx);
		case (idx)
			0, 4:    return ecode_ade;
			1:       return ecode_ale;
			2:       return 6'h1;
			3:       return 6'hb;
			default: return 6'h3f;
		endcase
	endfunction

	function automatic logic [xlen-1:0] estat_expect();
		return ref_cause | ref_regs[csr_estat] | (xlen'(ref_ti) << timer_int_bit);
	endfunction

	task automatic check_value(
		input string name,
		input logic [xlen-1:0] expected,
		input logic [xlen-1:0] actual
	);
		assert (actual === expected) else begin
			$display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
			$display("Done: errors found");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic write_csr(
		input logic [csr_num_w-1:0] num,
		input logic [xlen-1:0] mask,
		input logic [xlen-1:0] value
	);
		@(posedge clk);
		csr_we <= 1'b1;
		csr_wnum <= num;
		csr_wmask <= mask;
		csr_wvalue <= value;
		@(posedge clk);
		csr_we <= 1'b0;
	endtask

	task automatic write_ref(
		input logic [csr_num_w-1:0] num,
		input logic [xlen-1:0] mask,
		input logic [xlen-1:0] value
	);
		write_csr(num, mask, value);
		ref_regs[num] = merge_bits(ref_regs[num], value, mask) & keep_bits(num);
	endtask

	task automatic select_read(input logic [csr_num_w-1:0] num);
		@(posedge clk);
		csr_re <= 1'b1;
		csr_rnum <= num;
	endtask

	task automatic read_check(
		input logic [csr_num_w-1:0] num,
		input logic enable,
		input logic [xlen-1:0] expected
	);
		@(posedge clk);
		csr_re <= enable;
		csr_rnum <= num;
		@(negedge clk);
		check_value($sformatf("csr_rvalue (csr %0h)", num), expected, csr_rvalue);
	endtask

	task automatic raise_exception(
		input logic [ecode_w-1:0] ecode,
		input logic [esubcode_w-1:0] esubcode,
		input logic [xlen-1:0] pc,
		input logic [xlen-1:0] vaddr,
		input logic mem_inst
	);
		@(posedge clk);
		wb_ex <= 1'b1;
		wb_ecode <= ecode;
		wb_esubcode <= esubcode;
		wb_pc <= pc;
		wb_vaddr <= vaddr;
		ws_mem_inst <= mem_inst;
		// competing software write to era in the same cycle
		csr_we <= 1'b1;
		csr_wnum <= csr_era;
		csr_wmask <= 32'hffffffff;
		csr_wvalue <= ~pc;
		@(posedge clk);
		wb_ex <= 1'b0;
		csr_we <= 1'b0;
		ref_regs[csr_prmd] = ref_regs[csr_crmd] & 32'h7;
		ref_regs[csr_crmd] = ref_regs[csr_crmd] & 32'h18;
		ref_cause = {1'b0, esubcode, ecode, 16'h0};
		ref_regs[csr_era] = pc;
		if (ecode == ecode_ade || ecode == ecode_ale)
			ref_regs[csr_badv] = mem_inst ? vaddr : pc;
	endtask

	task automatic return_exception();
		@(posedge clk);
		eret_flush <= 1'b1;
		@(posedge clk);
		eret_flush <= 1'b0;
		ref_regs[csr_crmd] = (ref_regs[csr_crmd] & 32'h18) | (ref_regs[csr_prmd] & 32'h7);
	endtask

	task automatic check_int();
		logic [xlen-1:0] is_bits;
		logic            expected;
		is_bits = ref_regs[csr_estat] | (xlen'(ref_ti) << timer_int_bit);
		expected = (|(is_bits[11:0] & ref_regs[csr_ecfg][11:0])) & ref_regs[csr_crmd][2];
		@(negedge clk);
		check_value("has_int", xlen'(expected), xlen'(has_int));
	endtask

	initial begin
		#((test_cycles + 200) * 40);
		$display("watchdog expired before the tests finished");
		$display("Done: errors found");
		$fatal(1, "timeout");
	end

	initial begin
		int i;
		int k;
		logic [csr_num_w-1:0] num;
		logic [xlen-1:0]      load;
		logic [xlen-1:0]      expect_cnt;

		void'($urandom(44));
		rst = 1'b1;
		csr_re = 1'b0;
		csr_rnum = '0;
		csr_we = 1'b0;
		csr_wnum = '0;
		csr_wmask = '0;
		csr_wvalue = '0;
		wb_ex = 1'b0;
		wb_ecode = '0;
		wb_esubcode = '0;
		wb_pc = '0;
		wb_vaddr = '0;
		ws_mem_inst = 1'b0;
		eret_flush = 1'b0;
		for (i = 0; i < 128; i++)
			ref_regs[i] = '0;
		ref_regs[csr_crmd] = 32'h8;
		ref_cause = '0;
		ref_ti = 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		check_int();
		read_check(csr_crmd, 1'b1, 32'h8);
		read_check(csr_tavl, 1'b1, 32'hffffffff);

		// masked writes and readback
		for (i = 0; i < 9; i++)
			write_ref(rw_reg(i), 32'hffffffff, $urandom);
		for (i = 0; i < 9; i++)
			read_check(rw_reg(i), 1'b1, ref_regs[rw_reg(i)]);
		for (i = 0; i < 40; i++) begin
			num = rw_reg($urandom % 9);
			write_ref(num, $urandom, $urandom);
			read_check(num, 1'b1, ref_regs[num]);
			check_value("tid_rvalue", ref_regs[csr_tid], tid_rvalue);
		end
		read_check(14'h2, 1'b1, '0);
		read_check(14'h3fff, 1'b1, '0);
		read_check(csr_save0 + 14'd4, 1'b1, '0);
		read_check(csr_save0, 1'b0, '0);

		// exception entry and return
		for (i = 0; i < 6; i++) begin
			write_ref(csr_crmd, 32'h7, $urandom);
			raise_exception(ex_code(i), esubcode_w'($urandom), $urandom, $urandom, (i % 3) == 1);
			@(negedge clk);
			check_value("ex_entry", ref_regs[csr_eentry], ex_entry);
			read_check(csr_crmd, 1'b1, ref_regs[csr_crmd]);
			read_check(csr_prmd, 1'b1, ref_regs[csr_prmd]);
			read_check(csr_estat, 1'b1, estat_expect());
			read_check(csr_era, 1'b1, ref_regs[csr_era]);
			read_check(csr_badv, 1'b1, ref_regs[csr_badv]);
			return_exception();
			@(negedge clk);
			check_value("ertn_entry", ref_regs[csr_era], ertn_entry);
			read_check(csr_crmd, 1'b1, ref_regs[csr_crmd]);
		end

		// one-shot timer with the init field in units of four
		select_read(csr_tavl);
		write_ref(csr_tcfg, 32'hffffffff, 32'h11);
		load = 32'h11 & 32'hfffffffc;
		for (k = 0; k <= load; k++) begin
			@(negedge clk);
			check_value("tavl", load - k, csr_rvalue);
		end
		repeat (3) begin
			@(negedge clk);
			check_value("tavl", 32'hffffffff, csr_rvalue);
		end
		ref_ti = 1'b1;
		read_check(csr_estat, 1'b1, estat_expect());
		read_check(csr_tcfg, 1'b1, ref_regs[csr_tcfg]);

		// periodic timer over two reloads
		select_read(csr_tavl);
		write_ref(csr_tcfg, 32'hffffffff, 32'h0b);
		load = 32'h0b & 32'hfffffffc;
		expect_cnt = load;
		for (k = 0; k < 2 * (load + 1) + 1; k++) begin
			@(negedge clk);
			check_value("tavl", expect_cnt, csr_rvalue);
			expect_cnt = (expect_cnt == 0) ? load : expect_cnt - 1;
		end
		// the clear lands while the count is nonzero
		write_ref(csr_ticlr, 32'h1, 32'h1);
		ref_ti = 1'b0;
		write_ref(csr_tcfg, 32'h1, 32'h0);
		read_check(csr_tavl, 1'b1, load - 4);
		read_check(csr_estat, 1'b1, estat_expect());
		read_check(csr_ticlr, 1'b1, '0);

		// interrupt request from software bits
		for (i = 0; i < 12; i++) begin
			case ($urandom % 3)
				0:       write_ref(csr_ecfg, 32'hffffffff, $urandom & 32'h803);
				1:       write_ref(csr_estat, 32'h3, $urandom);
				default: write_ref(csr_crmd, 32'h4, $urandom);
			endcase
			check_int();
		end

		// interrupt request from the timer bit
		write_ref(csr_estat, 32'h3, 32'h0);
		write_ref(csr_ecfg, 32'hffffffff, 32'h800);
		write_ref(csr_crmd, 32'h4, 32'h4);
		write_ref(csr_tcfg, 32'hffffffff, 32'h5);
		check_int();
		repeat (5) @(posedge clk);
		ref_ti = 1'b1;
		check_int();
		read_check(csr_estat, 1'b1, estat_expect());
		write_ref(csr_crmd, 32'h4, 32'h0);
		check_int();

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
src/csr_pkg.sv
src/csr_exc_regs.sv
src/csr_int_timer.sv
src/csr_save_regs.sv
src/csr_read_mux.sv
src/csr_file.sv
tests/csr_tb.sv
